// ==== source/axi_sram_pkg.sv ====
`default_nettype none

package axi_sram_pkg;

    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;
    localparam int STRB_W   = DATA_W / 8;
    localparam int ID_W     = 8;
    localparam int LEN_W    = 4;
    localparam int SIZE_W   = 3;
    localparam int MAX_SIZE = 2; // Four bytes per beat

    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } burst_t;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01, // Never returned by this slave
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_t;

    // Classify a burst at its address transfer
    function automatic resp_t burst_resp(
        input logic [ADDR_W-1:0] addr,
        input logic [LEN_W-1:0]  len,
        input logic [SIZE_W-1:0] size,
        input logic [1:0]        burst,
        input logic [ADDR_W:0]   base,
        input logic [ADDR_W:0]   win_bytes
    );
        logic [ADDR_W:0] beats;
        logic [ADDR_W:0] last_byte;
        beats     = (burst == FIXED) ? (ADDR_W+1)'(1) : (ADDR_W+1)'(len) + 1'b1;
        last_byte = {1'b0, addr} + (beats << size) - 1'b1;
        if ({1'b0, addr} < base || last_byte >= base + win_bytes) begin
            return DECERR;
        end
        if (size > MAX_SIZE || !(burst inside {FIXED, INCR})) begin
            return SLVERR; // WRAP and reserved codes
        end
        return OKAY;
    endfunction

    function automatic logic [ADDR_W-1:0] next_addr(
        input logic [ADDR_W-1:0] addr,
        input logic [SIZE_W-1:0] size,
        input logic [1:0]        burst
    );
        if (burst == FIXED) begin
            return addr;
        end
        return addr + (ADDR_W'(1) << size);
    endfunction

endpackage

`default_nettype wire

// ==== source/sram_access_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface sram_access_if;
    import axi_sram_pkg::*;

    logic              req;
    logic              ack;
    logic              we;
    logic [ADDR_W-1:0] addr;  // Byte offset from the bank base
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
    logic [DATA_W-1:0] rdata; // Valid while ack is high

    modport client (
        output req,
        output we,
        output addr,
        output wdata,
        output wstrb,
        input  ack,
        input  rdata
    );

    modport bank (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        input  wstrb,
        output ack,
        output rdata
    );

endinterface

`default_nettype wire

// ==== source/axi_write_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_write_ctrl #(
    parameter int                              MEM_WORDS = 16384,
    parameter logic [axi_sram_pkg::ADDR_W-1:0] BASE_ADDR = 32'h0001_0000
) (
    input  wire                              ACLK,
    input  wire                              ARESETn,
    input  wire  [axi_sram_pkg::ID_W-1:0]    awid,
    input  wire  [axi_sram_pkg::ADDR_W-1:0]  awaddr,
    input  wire  [axi_sram_pkg::LEN_W-1:0]   awlen,
    input  wire  [axi_sram_pkg::SIZE_W-1:0]  awsize,
    input  wire  [1:0]                       awburst,
    input  wire                              awvalid,
    output logic                             awready,
    input  wire  [axi_sram_pkg::DATA_W-1:0]  wdata,
    input  wire  [axi_sram_pkg::STRB_W-1:0]  wstrb,
    input  wire                              wlast,
    input  wire                              wvalid,
    output logic                             wready,
    output logic [axi_sram_pkg::ID_W-1:0]    bid,
    output logic [1:0]                       bresp,
    output logic                             bvalid,
    input  wire                              bready,
    sram_access_if.client                    mem
);
    import axi_sram_pkg::*;

    localparam logic [ADDR_W:0] WIN_BYTES = (ADDR_W+1)'(MEM_WORDS * STRB_W);
    localparam logic [ADDR_W:0] BASE_EXT  = {1'b0, BASE_ADDR};

    typedef enum logic [2:0] {
        W_IDLE,
        W_DATA,
        W_REQ,
        W_DROP,
        W_SKIP,
        W_RESP
    } wstate_t;

    wstate_t           state_q;
    logic [ADDR_W-1:0] addr_q;
    logic [SIZE_W-1:0] size_q;
    logic [1:0]        burst_q;
    logic [ID_W-1:0]   id_q;
    resp_t             resp_q;
    resp_t             aw_resp;
    logic [DATA_W-1:0] wdata_q;
    logic [STRB_W-1:0] wstrb_q;
    logic              last_q;
    logic              aw_fire;
    logic              w_fire;
    logic              beat_done;

    assign aw_resp   = burst_resp(awaddr, awlen, awsize, awburst, BASE_EXT, WIN_BYTES);
    assign aw_fire   = awvalid && awready;
    assign w_fire    = wvalid && wready;
    assign beat_done = (state_q == W_DROP) && !mem.ack; // Four-phase cycle closed

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state_q <= W_IDLE;
        end else begin
            case (state_q)
                W_IDLE: begin
                    if (awvalid) begin
                        state_q <= W_DATA;
                    end
                end
                W_DATA: begin
                    if (wvalid) begin
                        if (resp_q == OKAY) begin
                            state_q <= W_REQ;
                        end else begin
                            state_q <= W_SKIP; // Beat dropped, no access
                        end
                    end
                end
                W_REQ: begin
                    if (mem.ack) begin
                        state_q <= W_DROP;
                    end
                end
                W_DROP, W_SKIP: begin
                    if (state_q == W_SKIP || !mem.ack) begin
                        state_q <= last_q ? W_RESP : W_DATA;
                    end
                end
                W_RESP: begin
                    if (bready) begin
                        state_q <= W_IDLE;
                    end
                end
                default: state_q <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge ACLK) begin
        if (aw_fire) begin
            addr_q  <= awaddr;
            size_q  <= awsize;
            burst_q <= awburst;
            id_q    <= awid;
            resp_q  <= aw_resp;
        end else if (beat_done) begin
            addr_q  <= next_addr(addr_q, size_q, burst_q);
        end
        if (w_fire) begin
            wdata_q <= wdata;
            wstrb_q <= wstrb;
            last_q  <= wlast;
        end
    end

    assign awready   = (state_q == W_IDLE);
    assign wready    = (state_q == W_DATA);
    assign bvalid    = (state_q == W_RESP);
    assign bid       = id_q;
    assign bresp     = resp_q;
    assign mem.req   = (state_q == W_REQ);
    assign mem.we    = 1'b1;
    assign mem.addr  = addr_q - BASE_ADDR;
    assign mem.wdata = wdata_q;
    assign mem.wstrb = wstrb_q;

    // Client side of the handshake with the bank
    assert property (@(posedge ACLK) disable iff (!ARESETn)
        mem.req && !mem.ack |=> mem.req);

    assert property (@(posedge ACLK) disable iff (!ARESETn)
        bvalid && !bready |=> bvalid && $stable(bresp) && $stable(bid));

endmodule

`default_nettype wire

// ==== source/axi_read_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_read_ctrl #(
    parameter int                              MEM_WORDS = 16384,
    parameter logic [axi_sram_pkg::ADDR_W-1:0] BASE_ADDR = 32'h0001_0000
) (
    input  wire                              ACLK,
    input  wire                              ARESETn,
    input  wire  [axi_sram_pkg::ID_W-1:0]    arid,
    input  wire  [axi_sram_pkg::ADDR_W-1:0]  araddr,
    input  wire  [axi_sram_pkg::LEN_W-1:0]   arlen,
    input  wire  [axi_sram_pkg::SIZE_W-1:0]  arsize,
    input  wire  [1:0]                       arburst,
    input  wire                              arvalid,
    output logic                             arready,
    output logic [axi_sram_pkg::ID_W-1:0]    rid,
    output logic [axi_sram_pkg::DATA_W-1:0]  rdata,
    output logic [1:0]                       rresp,
    output logic                             rlast,
    output logic                             rvalid,
    input  wire                              rready,
    sram_access_if.client                    mem
);
    import axi_sram_pkg::*;

    localparam logic [ADDR_W:0] WIN_BYTES = (ADDR_W+1)'(MEM_WORDS * STRB_W);
    localparam logic [ADDR_W:0] BASE_EXT  = {1'b0, BASE_ADDR};

    typedef enum logic [1:0] {
        R_IDLE,
        R_REQ,
        R_DROP,
        R_VALID
    } rstate_t;

    rstate_t           state_q;
    logic [LEN_W-1:0]  beat_q;
    logic [LEN_W-1:0]  len_q;
    logic [LEN_W-1:0]  xfer_q; // R transfers so far in this burst
    logic [ADDR_W-1:0] addr_q;
    logic [SIZE_W-1:0] size_q;
    logic [1:0]        burst_q;
    logic [ID_W-1:0]   id_q;
    resp_t             resp_q;
    resp_t             ar_resp;
    logic [DATA_W-1:0] rdata_q;
    logic              last_beat;
    logic              ar_fire;
    logic              r_fire;

    assign ar_resp   = burst_resp(araddr, arlen, arsize, arburst, BASE_EXT, WIN_BYTES);
    assign ar_fire   = arvalid && arready;
    assign r_fire    = rvalid && rready;
    assign last_beat = (beat_q == len_q);

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state_q <= R_IDLE;
            beat_q  <= '0;
        end else begin
            case (state_q)
                R_IDLE: begin
                    beat_q <= '0;
                    if (arvalid) begin
                        if (ar_resp == OKAY) begin
                            state_q <= R_REQ;
                        end else begin
                            state_q <= R_VALID; // Error beats need no access
                        end
                    end
                end
                R_REQ: begin
                    if (mem.ack) begin
                        state_q <= R_DROP;
                    end
                end
                R_DROP: begin
                    if (!mem.ack) begin
                        state_q <= R_VALID;
                    end
                end
                R_VALID: begin
                    if (rready) begin
                        if (last_beat) begin
                            state_q <= R_IDLE;
                        end else begin
                            beat_q <= beat_q + 1'b1;
                            if (resp_q == OKAY) begin
                                state_q <= R_REQ;
                            end
                        end
                    end
                end
                default: state_q <= R_IDLE;
            endcase
        end
    end

    always_ff @(posedge ACLK) begin
        if (ar_fire) begin
            addr_q  <= araddr;
            size_q  <= arsize;
            burst_q <= arburst;
            len_q   <= arlen;
            id_q    <= arid;
            resp_q  <= ar_resp;
            rdata_q <= '0; // Stays zero for error bursts
        end else if (r_fire && !last_beat) begin
            addr_q  <= next_addr(addr_q, size_q, burst_q);
        end
        if (state_q == R_REQ && mem.ack) begin
            rdata_q <= mem.rdata;
        end
    end

    // Counted from the R handshake alone
    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            xfer_q <= '0;
        end else if (ar_fire) begin
            xfer_q <= '0;
        end else if (r_fire) begin
            xfer_q <= xfer_q + 1'b1;
        end
    end

    assign arready   = (state_q == R_IDLE);
    assign rvalid    = (state_q == R_VALID);
    assign rlast     = rvalid && last_beat;
    assign rid       = id_q;
    assign rresp     = resp_q;
    assign rdata     = rdata_q;
    assign mem.req   = (state_q == R_REQ);
    assign mem.we    = 1'b0;
    assign mem.addr  = addr_q - BASE_ADDR;
    assign mem.wdata = '0;
    assign mem.wstrb = '0;

    assert property (@(posedge ACLK) disable iff (!ARESETn)
        rvalid && !rready |=> rvalid && $stable({rid, rdata, rresp, rlast}));

    // Last flag only on the beat numbered arlen
    assert property (@(posedge ACLK) disable iff (!ARESETn)
        rvalid |-> (rlast == (xfer_q == len_q)));

endmodule

`default_nettype wire

// ==== source/sram_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_bank #(
    parameter int MEM_WORDS = 16384
) (
    input  wire          ACLK,
    input  wire          ARESETn,
    sram_access_if.bank  wr,
    sram_access_if.bank  rd
);
    import axi_sram_pkg::*;

    localparam int WADDR_W = $clog2(MEM_WORDS);

    typedef enum logic [1:0] {
        B_IDLE,
        B_GRANT,
        B_ACK
    } bstate_t;

    bstate_t            state_q;
    logic               sel_q;  // High selects the read client
    logic               last_q; // Client served last
    logic               wr_ack_q;
    logic               rd_ack_q;
    logic               pick;
    logic               acc_req;
    logic               acc_we;
    logic [ADDR_W-1:0]  acc_addr;
    logic [WADDR_W-1:0] acc_waddr;
    logic [DATA_W-1:0]  acc_wdata;
    logic [STRB_W-1:0]  acc_wstrb;
    logic [DATA_W-1:0]  rdata_q;
    logic [DATA_W-1:0]  mem_q [MEM_WORDS];

    assign pick      = (wr.req && rd.req) ? !last_q : rd.req; // Alternate when both wait
    assign acc_req   = sel_q ? rd.req   : wr.req;
    assign acc_we    = sel_q ? rd.we    : wr.we;
    assign acc_addr  = sel_q ? rd.addr  : wr.addr;
    assign acc_wdata = sel_q ? rd.wdata : wr.wdata;
    assign acc_wstrb = sel_q ? rd.wstrb : wr.wstrb;
    assign acc_waddr = acc_addr[WADDR_W+1:2];

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state_q  <= B_IDLE;
            sel_q    <= 1'b0;
            last_q   <= 1'b1;
            wr_ack_q <= 1'b0;
            rd_ack_q <= 1'b0;
        end else begin
            case (state_q)
                B_IDLE: begin
                    if (wr.req || rd.req) begin
                        sel_q   <= pick;
                        state_q <= B_GRANT;
                    end
                end
                B_GRANT: begin
                    wr_ack_q <= !sel_q;
                    rd_ack_q <= sel_q;
                    state_q  <= B_ACK;
                end
                B_ACK: begin
                    if (!acc_req) begin
                        wr_ack_q <= 1'b0;
                        rd_ack_q <= 1'b0;
                        last_q   <= sel_q;
                        state_q  <= B_IDLE;
                    end
                end
                default: state_q <= B_IDLE;
            endcase
        end
    end

    // Array access on the edge that raises ack
    always_ff @(posedge ACLK) begin
        if (state_q == B_GRANT) begin
            rdata_q <= mem_q[acc_waddr];
            if (acc_we) begin
                for (int i = 0; i < STRB_W; i++) begin
                    if (acc_wstrb[i]) begin
                        mem_q[acc_waddr][8*i +: 8] <= acc_wdata[8*i +: 8];
                    end
                end
            end
        end
    end

    assign wr.ack   = wr_ack_q;
    assign rd.ack   = rd_ack_q;
    assign wr.rdata = rdata_q;
    assign rd.rdata = rdata_q;

    assert property (@(posedge ACLK) disable iff (!ARESETn)
        !(wr.ack && rd.ack));

endmodule

`default_nettype wire

// ==== source/sram_wrapper_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_wrapper_top #(
    parameter int                              MEM_WORDS = 16384, // 14-bit word address
    parameter logic [axi_sram_pkg::ADDR_W-1:0] BASE_ADDR = 32'h0001_0000
) (
    input  wire                              ACLK,
    input  wire                              ARESETn,
    input  wire  [axi_sram_pkg::ID_W-1:0]    awid,
    input  wire  [axi_sram_pkg::ADDR_W-1:0]  awaddr,
    input  wire  [axi_sram_pkg::LEN_W-1:0]   awlen,
    input  wire  [axi_sram_pkg::SIZE_W-1:0]  awsize,
    input  wire  [1:0]                       awburst,
    input  wire                              awvalid,
    output logic                             awready,
    input  wire  [axi_sram_pkg::DATA_W-1:0]  wdata,
    input  wire  [axi_sram_pkg::STRB_W-1:0]  wstrb,
    input  wire                              wlast,
    input  wire                              wvalid,
    output logic                             wready,
    output logic [axi_sram_pkg::ID_W-1:0]    bid,
    output logic [1:0]                       bresp,
    output logic                             bvalid,
    input  wire                              bready,
    input  wire  [axi_sram_pkg::ID_W-1:0]    arid,
    input  wire  [axi_sram_pkg::ADDR_W-1:0]  araddr,
    input  wire  [axi_sram_pkg::LEN_W-1:0]   arlen,
    input  wire  [axi_sram_pkg::SIZE_W-1:0]  arsize,
    input  wire  [1:0]                       arburst,
    input  wire                              arvalid,
    output logic                             arready,
    output logic [axi_sram_pkg::ID_W-1:0]    rid,
    output logic [axi_sram_pkg::DATA_W-1:0]  rdata,
    output logic [1:0]                       rresp,
    output logic                             rlast,
    output logic                             rvalid,
    input  wire                              rready
);

    sram_access_if wr_port ();
    sram_access_if rd_port ();

    axi_write_ctrl #(
        .MEM_WORDS (MEM_WORDS),
        .BASE_ADDR (BASE_ADDR)
    ) i_axi_write_ctrl (
        .ACLK    (ACLK),
        .ARESETn (ARESETn),
        .awid    (awid),
        .awaddr  (awaddr),
        .awlen   (awlen),
        .awsize  (awsize),
        .awburst (awburst),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wlast   (wlast),
        .wvalid  (wvalid),
        .wready  (wready),
        .bid     (bid),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .mem     (wr_port.client)
    );

    axi_read_ctrl #(
        .MEM_WORDS (MEM_WORDS),
        .BASE_ADDR (BASE_ADDR)
    ) i_axi_read_ctrl (
        .ACLK    (ACLK),
        .ARESETn (ARESETn),
        .arid    (arid),
        .araddr  (araddr),
        .arlen   (arlen),
        .arsize  (arsize),
        .arburst (arburst),
        .arvalid (arvalid),
        .arready (arready),
        .rid     (rid),
        .rdata   (rdata),
        .rresp   (rresp),
        .rlast   (rlast),
        .rvalid  (rvalid),
        .rready  (rready),
        .mem     (rd_port.client)
    );

    sram_bank #(
        .MEM_WORDS (MEM_WORDS)
    ) i_sram_bank (
        .ACLK    (ACLK),
        .ARESETn (ARESETn),
        .wr      (wr_port.bank),
        .rd      (rd_port.bank)
    );

endmodule

`default_nettype wire

// ==== test/tb_axi_master.svh ====
`ifndef TB_AXI_MASTER_SVH
`define TB_AXI_MASTER_SVH

// Next rising edge plus the 1 ns drive delay
task automatic step();
    @(posedge ACLK);
    #1;
endtask

task automatic drive_idle();
    awid    = '0;
    awaddr  = '0;
    awlen   = '0;
    awsize  = '0;
    awburst = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wlast   = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    arid    = '0;
    araddr  = '0;
    arlen   = '0;
    arsize  = '0;
    arburst = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
endtask

function automatic logic sample_flag(input string name);
    case (name)
        "awready": return awready;
        "wready":  return wready;
        "bvalid":  return bvalid;
        "arready": return arready;
        default:   return rvalid;
    endcase
endfunction

// Flags come from registered state, stable between edges
task automatic await_flag(input string name, input int timeout);
    int cycles;
    cycles = 0;
    while (!sample_flag(name) && cycles < timeout) begin
        step();
        cycles++;
    end
    if (!sample_flag(name)) begin
        $display("Handshake lost: %s stayed low for %0d cycles at %0t", name, timeout, $time);
        errors++;
    end
endtask

// Beats come from wr_data and wr_strb, the response lands in b_id and b_resp
task automatic write_burst(
    input logic [ID_W-1:0]   id,
    input logic [ADDR_W-1:0] addr,
    input logic [LEN_W-1:0]  len,
    input logic [SIZE_W-1:0] size,
    input logic [1:0]        burst,
    input int                timeout
);
    awid    = id;
    awaddr  = addr;
    awlen   = len;
    awsize  = size;
    awburst = burst;
    awvalid = 1'b1;
    await_flag("awready", timeout);
    step();
    awvalid = 1'b0;
    for (int i = 0; i <= int'(len); i++) begin
        wdata  = wr_data[i];
        wstrb  = wr_strb[i];
        wlast  = (i == int'(len));
        wvalid = 1'b1;
        await_flag("wready", timeout);
        step();
    end
    wvalid = 1'b0;
    wlast  = 1'b0;
    bready = 1'b1;
    await_flag("bvalid", timeout);
    b_id   = bid;
    b_resp = bresp;
    step();
    bready = 1'b0;
endtask

// Collects R beats into rd_data, rd_resp and rd_last until rlast
task automatic read_burst(
    input logic [ID_W-1:0]   id,
    input logic [ADDR_W-1:0] addr,
    input logic [LEN_W-1:0]  len,
    input logic [SIZE_W-1:0] size,
    input logic [1:0]        burst,
    input int                timeout,
    input logic              stall // Random rready when set
);
    int   idle;
    logic done;
    arid    = id;
    araddr  = addr;
    arlen   = len;
    arsize  = size;
    arburst = burst;
    arvalid = 1'b1;
    await_flag("arready", timeout);
    step();
    arvalid  = 1'b0;
    rd_count = 0;
    idle     = 0;
    done     = 1'b0;
    while (!done && idle < timeout) begin
        rready = stall ? next_bit() : 1'b1;
        if (rvalid && rready) begin
            rd_data[rd_count] = rdata;
            rd_resp[rd_count] = rresp;
            rd_last[rd_count] = rlast;
            rd_id             = rid;
            rd_count++;
            done = rlast || (rd_count == 17);
            idle = 0;
        end else begin
            idle++;
        end
        step();
    end
    rready = 1'b0;
    if (!done) begin
        $display("Read burst stalled: no R beat for %0d cycles at %0t", timeout, $time);
        errors++;
    end
endtask

`endif

// ==== test/tb_sram_wrapper.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sram_wrapper;
    import axi_sram_pkg::*;

    localparam int                MEM_WORDS       = 16384;
    localparam logic [ADDR_W-1:0] BASE_ADDR       = 32'h0001_0000;
    localparam logic [31:0]       SEED            = 32'h632;
    localparam int                CLK_PERIOD      = 10;
    localparam int                CYCLES_PER_BEAT = 20;
    localparam int                TOTAL_BEATS     = 105; // Sum over the six tests
    localparam int                TIMEOUT         = 100; // Cycles per handshake

    logic                ACLK;
    logic                ARESETn;
    logic [ID_W-1:0]     awid, bid, arid, rid;
    logic [ADDR_W-1:0]   awaddr, araddr;
    logic [LEN_W-1:0]    awlen, arlen;
    logic [SIZE_W-1:0]   awsize, arsize;
    logic [1:0]          awburst, arburst, bresp, rresp;
    logic [DATA_W-1:0]   wdata, rdata;
    logic [STRB_W-1:0]   wstrb;
    logic                awvalid, awready, wlast, wvalid, wready, bvalid, bready;
    logic                arvalid, arready, rlast, rvalid, rready;

    logic [31:0]         lfsr_q;
    int                  errors;
    int                  tests_passed;
    int                  tests_failed;
    logic [DATA_W-1:0]   ref_mem [int]; // Word index from BASE_ADDR
    logic [DATA_W-1:0]   wr_data [16];
    logic [STRB_W-1:0]   wr_strb [16];
    logic [DATA_W-1:0]   rd_data [17];
    logic [1:0]          rd_resp [17];
    logic                rd_last [17];
    int                  rd_count;
    logic [ID_W-1:0]     rd_id;
    logic [ID_W-1:0]     b_id;
    logic [1:0]          b_resp;

    sram_wrapper_top #(
        .MEM_WORDS (MEM_WORDS),
        .BASE_ADDR (BASE_ADDR)
    ) i_sram_wrapper_top (.*);

    initial begin
        ACLK = 1'b0;
        forever #(CLK_PERIOD / 2) ACLK = ~ACLK;
    end

    // Taps 32, 22, 2, 1
    function automatic logic next_bit();
        logic fb;
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    function automatic void ref_write(
        input logic [ADDR_W-1:0] addr,
        input logic [DATA_W-1:0] data,
        input logic [STRB_W-1:0] strb
    );
        int                idx;
        logic [DATA_W-1:0] word;
        idx  = int'((addr - BASE_ADDR) >> 2);
        word = ref_mem.exists(idx) ? ref_mem[idx] : '0;
        for (int i = 0; i < STRB_W; i++) begin
            if (strb[i]) begin
                word[8*i +: 8] = data[8*i +: 8];
            end
        end
        ref_mem[idx] = word;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    `include "tb_axi_master.svh"

    task automatic finish_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("%s: passed", name);
            tests_passed++;
        end else begin
            $display("%s: failed with %0d errors", name, errors - errors_before);
            tests_failed++;
        end
    endtask

    function automatic void fill_random(input int beats);
        for (int i = 0; i < beats; i++) begin
            wr_data[i] = rand_bits(32);
            wr_strb[i] = 4'hf;
        end
    endfunction

    function automatic void commit_words(input logic [ADDR_W-1:0] addr, input int beats);
        for (int i = 0; i < beats; i++) begin
            ref_write(addr + 32'(4 * i), wr_data[i], wr_strb[i]);
        end
    endfunction

    // Full-word INCR write inside the window
    task automatic write_words(input string name, input logic [ADDR_W-1:0] addr,
                               input int beats);
        fill_random(beats);
        write_burst(8'h5a, addr, LEN_W'(beats - 1), 3'd2, INCR, TIMEOUT);
        check_value({name, " bresp"}, 32'(OKAY), 32'(b_resp));
        commit_words(addr, beats);
    endtask

    task automatic check_beats(
        input string             name,
        input logic [ADDR_W-1:0] addr,
        input int                len,
        input int                stride, // Words per beat, zero for FIXED
        input logic [1:0]        resp
    );
        int          idx;
        logic [31:0] expected;
        idx = int'((addr - BASE_ADDR) >> 2);
        check_value({name, " beat count"}, 32'(len + 1), 32'(rd_count));
        for (int i = 0; i < rd_count; i++) begin
            expected = (resp == OKAY) ? ref_mem[idx + i * stride] : '0;
            check_value({name, " rresp"}, 32'(resp), 32'(rd_resp[i]));
            check_value({name, " rlast"}, 32'(i == len), 32'(rd_last[i]));
            check_value({name, " rdata"}, expected, rd_data[i]);
        end
    endtask

    task automatic test_single();
        int                err0;
        logic [ADDR_W-1:0] addr;
        err0       = errors;
        addr       = BASE_ADDR + 32'h40;
        wr_data[0] = rand_bits(32);
        wr_strb[0] = 4'hf;
        write_burst(8'h11, addr, 4'd0, 3'd2, FIXED, TIMEOUT);
        ref_write(addr, wr_data[0], wr_strb[0]);
        check_value("single bresp", 32'(OKAY), 32'(b_resp));
        check_value("single bid", 32'h11, 32'(b_id));
        read_burst(8'h22, addr, 4'd0, 3'd2, FIXED, TIMEOUT, 1'b0);
        check_value("single rid", 32'h22, 32'(rd_id));
        check_beats("single", addr, 0, 0, OKAY);
        finish_test("single write and read", err0);
    endtask

    task automatic test_byte_lanes();
        int                err0;
        logic [3:0]        lanes [3];
        logic [ADDR_W-1:0] addr;
        err0  = errors;
        lanes = '{4'b0001, 4'b0110, 4'b1010};
        addr  = BASE_ADDR + 32'h80;
        write_words("lanes", addr, 1);
        for (int k = 0; k < 3; k++) begin
            wr_data[0] = rand_bits(32);
            wr_strb[0] = lanes[k];
            write_burst(8'h20 + 8'(k), addr, 4'd0, 3'd2, FIXED, TIMEOUT);
            check_value("lanes bresp", 32'(OKAY), 32'(b_resp));
            ref_write(addr, wr_data[0], wr_strb[0]);
        end
        read_burst(8'h2f, addr, 4'd0, 3'd2, FIXED, TIMEOUT, 1'b0);
        check_beats("lanes", addr, 0, 0, OKAY);
        finish_test("byte lanes", err0);
    endtask

    task automatic test_incr_burst();
        int                err0;
        logic [ADDR_W-1:0] addr;
        err0 = errors;
        addr = BASE_ADDR + 32'h100;
        write_words("incr", addr, 16);
        read_burst(8'h33, addr, 4'd15, 3'd2, INCR, TIMEOUT, 1'b1);
        check_value("incr rid", 32'h33, 32'(rd_id));
        check_beats("incr", addr, 15, 1, OKAY);
        finish_test("INCR burst with back-pressure", err0);
    endtask

    task automatic test_window();
        int                err0;
        logic [ADDR_W-1:0] win_end;
        err0    = errors;
        win_end = BASE_ADDR + 32'(MEM_WORDS * 4);
        write_words("window", win_end - 32'd8, 2);
        fill_random(4);
        write_burst(8'h41, BASE_ADDR - 32'd8, 4'd1, 3'd2, INCR, TIMEOUT);
        check_value("window low bresp", 32'(DECERR), 32'(b_resp));
        write_burst(8'h42, win_end - 32'd8, 4'd3, 3'd2, INCR, TIMEOUT);
        check_value("window high bresp", 32'(DECERR), 32'(b_resp));
        read_burst(8'h43, BASE_ADDR - 32'd8, 4'd1, 3'd2, INCR, TIMEOUT, 1'b0);
        check_beats("window low read", BASE_ADDR - 32'd8, 1, 1, DECERR);
        read_burst(8'h44, win_end - 32'd8, 4'd3, 3'd2, INCR, TIMEOUT, 1'b1);
        check_beats("window high read", win_end - 32'd8, 3, 1, DECERR);
        read_burst(8'h45, win_end - 32'd8, 4'd1, 3'd2, INCR, TIMEOUT, 1'b0);
        check_beats("window readback", win_end - 32'd8, 1, 1, OKAY);
        finish_test("address outside the window", err0);
    endtask

    task automatic test_size_wrap();
        int                err0;
        logic [ADDR_W-1:0] addr;
        err0 = errors;
        addr = BASE_ADDR + 32'h200;
        write_words("size", addr, 4);
        fill_random(4);
        write_burst(8'h51, addr, 4'd0, 3'd3, FIXED, TIMEOUT); // Eight bytes
        check_value("size bresp", 32'(SLVERR), 32'(b_resp));
        read_burst(8'h52, addr, 4'd0, 3'd3, FIXED, TIMEOUT, 1'b0);
        check_beats("size read", addr, 0, 0, SLVERR);
        write_burst(8'h53, addr, 4'd3, 3'd2, WRAP, TIMEOUT);
        check_value("wrap bresp", 32'(SLVERR), 32'(b_resp));
        read_burst(8'h54, addr, 4'd3, 3'd2, WRAP, TIMEOUT, 1'b0);
        check_beats("wrap read", addr, 3, 1, SLVERR);
        read_burst(8'h55, addr, 4'd3, 3'd2, INCR, TIMEOUT, 1'b0);
        check_beats("size readback", addr, 3, 1, OKAY);
        finish_test("size above four bytes and WRAP", err0);
    endtask

    task automatic test_concurrent();
        int                err0;
        logic [ADDR_W-1:0] rd_base;
        logic [ADDR_W-1:0] wr_base;
        err0    = errors;
        rd_base = BASE_ADDR + 32'h400;
        wr_base = BASE_ADDR + 32'h800;
        write_words("concurrent", rd_base, 8);
        fill_random(8);
        fork
            write_burst(8'h61, wr_base, 4'd7, 3'd2, INCR, TIMEOUT);
            read_burst(8'h62, rd_base, 4'd7, 3'd2, INCR, TIMEOUT, 1'b1);
        join
        check_value("concurrent bresp", 32'(OKAY), 32'(b_resp));
        check_value("concurrent bid", 32'h61, 32'(b_id));
        check_value("concurrent rid", 32'h62, 32'(rd_id));
        check_beats("concurrent read", rd_base, 7, 1, OKAY);
        commit_words(wr_base, 8);
        read_burst(8'h63, wr_base, 4'd7, 3'd2, INCR, TIMEOUT, 1'b0);
        check_beats("concurrent readback", wr_base, 7, 1, OKAY);
        finish_test("concurrent bursts", err0);
    endtask

    initial begin
        #(TOTAL_BEATS * CYCLES_PER_BEAT * CLK_PERIOD);
        $display("Run timed out at %0t before all tests finished", $time);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        lfsr_q       = SEED;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        ARESETn      = 1'b0;
        drive_idle();
        repeat (10) @(posedge ACLK);
        #1;
        ARESETn = 1'b1;
        step();
        test_single();
        test_byte_lanes();
        test_incr_burst();
        test_window();
        test_size_wrap();
        test_concurrent();
        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sram_wrapper_top.f ====
+incdir+test
source/axi_sram_pkg.sv
source/sram_access_if.sv
source/axi_write_ctrl.sv
source/axi_read_ctrl.sv
source/sram_bank.sv
source/sram_wrapper_top.sv
test/tb_sram_wrapper.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_sram_wrapper
LINT_TOP   ?= sram_wrapper_top
FILELIST   ?= sram_wrapper_top.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
PASS_MSG   ?= RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Status comes from the search for the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^$(PASS_MSG)$$"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
